// File: design/isa_pkg.sv
package isa_pkg;

    // architectural register file size
    localparam int NUM_REGS = 32;

    // register index width, log2 of the register count
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // datapath word
    typedef logic [31:0] word_t;

    // coarse operation class, all the pairing rules care about
    // nop at zero so a cleared entry decodes as harmless
    typedef enum logic [2:0] {
        // bubble or real nop
        OP_NOP     = 3'd0,
        // plain integer op, single cycle in execute
        OP_ALU     = 3'd1,
        // mult/div, result lands in hi/lo
        OP_MD      = 3'd2,
        // mfhi/mflo, reads hi/lo
        OP_HILO_RD = 3'd3,
        // branch or jump, next entry is its delay slot
        OP_BRANCH  = 3'd4,
        // syscall/eret class, never paired
        OP_TRAP    = 3'd5
    } op_class_t;

endpackage

// File: design/issue_ctrl.sv
module issue_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       md_busy,
    input  logic [1:0]                 issue_en,
    input  pipe_pkg::dec_entry_t [1:0] head_entry,
    input  logic                       iss_ready,
    output logic                       md_start,
    output logic                       md_block,
    output logic                       accept_en
);

    typedef enum logic [1:0] {
        RUN     = 2'd0,
        MD_WAIT = 2'd1,
        FLUSH   = 2'd2
    } state_t;

    state_t state;
    logic   md_issue;

    // mult/div in either issuing slot, at most one per pair
    always_comb begin
        md_issue = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (issue_en[i] && (head_entry[i].op == isa_pkg::OP_MD)) begin
                md_issue = 1'b1;
            end
        end
    end

    // only counts once execute takes the pair
    assign md_start = md_issue && iss_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= FLUSH;
        end else begin
            case (state)
                // one dead cycle to let the queue settle empty
                FLUSH: state <= RUN;
                RUN: begin
                    if (md_start) begin
                        state <= MD_WAIT;
                    end
                end
                MD_WAIT: begin
                    if (!md_busy) begin
                        state <= RUN;
                    end
                end
                default: state <= FLUSH;
            endcase
        end
    end

    assign md_block = state == MD_WAIT;

    // no issue and no enqueue on a flush edge or the cycle after
    assign accept_en = (state != FLUSH) && !flush;

endmodule

// File: design/issue_queue.sv
module issue_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       accept_en,
    input  logic [1:0]                 dec_valid,
    input  pipe_pkg::dec_entry_t [1:0] dec_entry,
    output logic                       dec_ready,
    input  logic [1:0]                 issue_en,
    input  logic                       iss_ready,
    output pipe_pkg::dec_entry_t [1:0] head_entry,
    output logic [1:0]                 head_valid
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // bank 0 even, bank 1 odd
    pipe_pkg::dec_entry_t mem [2][QUEUE_DEPTH];

    // pointers carry one extra wrap bit for full/empty
    logic [PTR_W:0] head [2];
    logic [PTR_W:0] tail [2];

    // bank that takes the older decode slot next
    logic enq_sel;
    logic enq_yng;
    // bank holding the oldest entry
    logic deq_sel;
    logic deq_yng;

    logic [1:0] empty;
    logic [1:0] full;
    logic [1:0] push_bank;
    logic [1:0] pop_bank;
    logic       push;

    assign enq_yng = ~enq_sel;
    assign deq_yng = ~deq_sel;

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            empty[b] = head[b] == tail[b];
            // same index, opposite wrap bit
            full[b] = (head[b] ^ tail[b]) == {1'b1, {PTR_W{1'b0}}};
        end
    end

    // each bank must have room for one, a pair takes one per bank
    assign dec_ready = accept_en && !full[0] && !full[1];
    assign push = dec_ready && (dec_valid != 2'b00);

    always_comb begin
        push_bank = 2'b00;
        pop_bank = 2'b00;
        if (push) begin
            push_bank[enq_sel] = dec_valid[1];
            push_bank[enq_yng] = dec_valid[0];
        end
        if (iss_ready) begin
            pop_bank[deq_sel] = issue_en[1];
            pop_bank[deq_yng] = issue_en[0];
        end
    end

    // head pair in program order, older from the deq_sel bank
    // strict alternation means older empty implies queue empty
    assign head_valid[1] = !empty[deq_sel];
    assign head_valid[0] = !empty[deq_yng];
    assign head_entry[1] = mem[deq_sel][head[deq_sel][PTR_W-1:0]];
    assign head_entry[0] = mem[deq_yng][head[deq_yng][PTR_W-1:0]];

    // payload write, no reset
    always_ff @(posedge clk) begin
        if (push_bank[enq_sel]) begin
            mem[enq_sel][tail[enq_sel][PTR_W-1:0]] <= dec_entry[1];
        end
        if (push_bank[enq_yng]) begin
            mem[enq_yng][tail[enq_yng][PTR_W-1:0]] <= dec_entry[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head[0] <= '0;
            head[1] <= '0;
            tail[0] <= '0;
            tail[1] <= '0;
            enq_sel <= 1'b0;
            deq_sel <= 1'b0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (push_bank[b]) begin
                    tail[b] <= tail[b] + 1'b1;
                end
                if (pop_bank[b]) begin
                    head[b] <= head[b] + 1'b1;
                end
            end
            // a single entry flips the steering, a pair keeps it
            if (push && (dec_valid[1] ^ dec_valid[0])) begin
                enq_sel <= enq_yng;
            end
            if (iss_ready && (issue_en[1] ^ issue_en[0])) begin
                deq_sel <= deq_yng;
            end
        end
    end

endmodule

// File: design/issue_stage.sv
module issue_stage #(
    parameter int QUEUE_DEPTH = 8,
    parameter int MD_LATENCY  = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [1:0]                 dec_valid,
    input  pipe_pkg::dec_entry_t [1:0] dec_entry,
    output logic                       dec_ready,
    output logic [1:0]                 iss_valid,
    output pipe_pkg::dec_entry_t [1:0] iss_entry,
    output isa_pkg::word_t [1:0]       iss_rs_data,
    output isa_pkg::word_t [1:0]       iss_rt_data,
    input  logic                       iss_ready,
    input  logic [1:0]                 wb_en,
    input  isa_pkg::reg_idx_t [1:0]    wb_rd,
    input  isa_pkg::word_t [1:0]       wb_data
);

    // head pair goes straight out as iss_entry
    // issue enables double as iss_valid
    logic [1:0] head_valid;
    logic [1:0] rs_ready;
    logic [1:0] rt_ready;
    logic       md_block;
    logic       accept_en;
    logic       md_start;
    logic       md_busy;

    issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .reset(reset), .flush(flush), .accept_en(accept_en),
        .dec_valid(dec_valid), .dec_entry(dec_entry), .dec_ready(dec_ready),
        .issue_en(iss_valid), .iss_ready(iss_ready),
        .head_entry(iss_entry), .head_valid(head_valid)
    );

    pair_check u_pair (
        .head_entry(iss_entry), .head_valid(head_valid),
        .rs_ready(rs_ready), .rt_ready(rt_ready),
        .md_block(md_block), .accept_en(accept_en), .issue_en(iss_valid)
    );

    md_timer #(.MD_LATENCY(MD_LATENCY)) u_md_timer (
        .clk(clk), .reset(reset), .flush(flush),
        .md_start(md_start), .md_busy(md_busy)
    );

    issue_ctrl u_ctrl (
        .clk(clk), .reset(reset), .flush(flush), .md_busy(md_busy),
        .issue_en(iss_valid), .head_entry(iss_entry), .iss_ready(iss_ready),
        .md_start(md_start), .md_block(md_block), .accept_en(accept_en)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .flush(flush),
        .head_entry(iss_entry), .issue_en(iss_valid), .iss_ready(iss_ready),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs_ready(rs_ready), .rt_ready(rt_ready),
        .rs_data(iss_rs_data), .rt_data(iss_rt_data)
    );

endmodule

// File: design/md_timer.sv
module md_timer #(
    parameter int MD_LATENCY = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic md_start,
    output logic md_busy
);

    localparam int CNT_W = $clog2(MD_LATENCY + 1);

    // cycles left before the unit takes another op
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else if (md_start) begin
            count <= CNT_W'(MD_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // still busy after the coming edge
    // at count one the last blocked edge is the next one,
    // so the controller may leave its wait state on it
    assign md_busy = count > CNT_W'(1);

endmodule

// File: design/pair_check.sv
module pair_check (
    input  pipe_pkg::dec_entry_t [1:0] head_entry,
    input  logic [1:0]                 head_valid,
    input  logic [1:0]                 rs_ready,
    input  logic [1:0]                 rt_ready,
    input  logic                       md_block,
    input  logic                       accept_en,
    output logic [1:0]                 issue_en
);

    pipe_pkg::dec_entry_t older;
    pipe_pkg::dec_entry_t younger;

    logic older_md;
    logic younger_md;
    logic older_can;
    logic raw_hazard;
    logic hilo_hazard;
    logic class_ok;
    logic younger_ok;

    // slot 1 is the older of the head pair
    assign older = head_entry[1];
    assign younger = head_entry[0];

    assign older_md = older.op == isa_pkg::OP_MD;
    assign younger_md = younger.op == isa_pkg::OP_MD;

    // older alone, ignoring its delay slot partner
    assign older_can = accept_en && head_valid[1]
                       && rs_ready[1] && rt_ready[1]
                       && !(older_md && md_block);

    // younger reads what older writes in the same pair
    // r0 writes are dropped so they create no dependency
    assign raw_hazard = older.writes_rd && (older.rd != '0)
                        && ((older.rd == younger.rs) || (older.rd == younger.rt));

    // hi/lo not written yet when the read would go
    assign hilo_hazard = older_md && (younger.op == isa_pkg::OP_HILO_RD);

    // younger class limits
    // branch needs its own slot, trap goes alone either way
    assign class_ok = (younger.op != isa_pkg::OP_BRANCH)
                      && (younger.op != isa_pkg::OP_TRAP)
                      && (older.op != isa_pkg::OP_TRAP);

    // younger can go beside the older
    // one mult/div unit, so never two per pair and never while busy
    assign younger_ok = head_valid[0]
                        && rs_ready[0] && rt_ready[0]
                        && class_ok
                        && !raw_hazard
                        && !hilo_hazard
                        && !(older_md && younger_md)
                        && !(younger_md && md_block);

    // a branch only leaves together with its delay slot
    assign issue_en[1] = older_can
                         && ((older.op != isa_pkg::OP_BRANCH) || younger_ok);

    // younger never overtakes
    assign issue_en[0] = issue_en[1] && younger_ok;

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    // width of the program order tag
    localparam int TAG_W = 8;

    // sequence number from decode, wraps freely
    typedef logic [TAG_W-1:0] tag_t;

    // one decoded instruction as it sits in the issue queue
    // moves between decode, queue and execute as a unit
    typedef struct packed {
        // program order
        tag_t                tag;
        // class used by the pairing rules
        isa_pkg::op_class_t  op;
        // first source register
        isa_pkg::reg_idx_t   rs;
        // second source register
        isa_pkg::reg_idx_t   rt;
        // destination register
        isa_pkg::reg_idx_t   rd;
        // set when rd is really written
        logic                writes_rd;
        // raw immediate field, only carried through
        logic [15:0]         imm;
    } dec_entry_t;

endpackage

// File: design/reg_file.sv
module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  pipe_pkg::dec_entry_t [1:0] head_entry,
    input  logic [1:0]                 issue_en,
    input  logic                       iss_ready,
    input  logic [1:0]                 wb_en,
    input  isa_pkg::reg_idx_t [1:0]    wb_rd,
    input  isa_pkg::word_t [1:0]       wb_data,
    output logic [1:0]                 rs_ready,
    output logic [1:0]                 rt_ready,
    output isa_pkg::word_t [1:0]       rs_data,
    output isa_pkg::word_t [1:0]       rt_data
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    // one bit per register with a write in flight
    logic [isa_pkg::NUM_REGS-1:0] pending;
    logic [isa_pkg::NUM_REGS-1:0] next_pending;

    // free now, or its writeback lands this cycle
    function automatic logic avail(isa_pkg::reg_idx_t r);
        logic hit;
        hit = (wb_en[0] && (wb_rd[0] == r)) || (wb_en[1] && (wb_rd[1] == r));
        return (r == '0) || !pending[r] || hit;
    endfunction

    // younger writeback slot wins on the same rd
    function automatic isa_pkg::word_t read_fwd(isa_pkg::reg_idx_t r);
        isa_pkg::word_t val;
        val = regs[r];
        if (wb_en[1] && (wb_rd[1] == r)) val = wb_data[1];
        if (wb_en[0] && (wb_rd[0] == r)) val = wb_data[0];
        if (r == '0) val = '0;
        return val;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rs_ready[i] = avail(head_entry[i].rs);
            // rt side also holds off a second writer to a pending rd
            rt_ready[i] = avail(head_entry[i].rt)
                          && (!head_entry[i].writes_rd || avail(head_entry[i].rd));
            rs_data[i] = read_fwd(head_entry[i].rs);
            rt_data[i] = read_fwd(head_entry[i].rt);
        end
    end

    // older slot first so the younger one lands last
    always_ff @(posedge clk) begin
        for (int i = 1; i >= 0; i--) begin
            if (wb_en[i]) regs[wb_rd[i]] <= wb_data[i];
        end
    end

    // clear on writeback, then set for new writers
    always_comb begin
        next_pending = pending;
        for (int i = 0; i < 2; i++) begin
            if (wb_en[i]) next_pending[wb_rd[i]] = 1'b0;
        end
        for (int i = 0; i < 2; i++) begin
            if (iss_ready && issue_en[i] && head_entry[i].writes_rd) begin
                next_pending[head_entry[i].rd] = 1'b1;
            end
        end
        next_pending[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) pending <= '0;
        else pending <= next_pending;
    end

endmodule

// File: dual_issue.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/issue_queue.sv
design/pair_check.sv
design/md_timer.sv
design/issue_ctrl.sv
design/reg_file.sv
design/issue_stage.sv
testbench/tb_clock.sv
testbench/issue_stage_asserts.sv
testbench/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module issue_stage_tb \
    -f dual_issue.f -o sim_issue > build.log 2>&1 \
    && ./obj_dir/sim_issue +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation stopped early" >> sim.log
if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "simulation failed, see sim.log and build.log"
    exit 1
fi
echo "simulation passed"

// File: testbench/issue_stage_asserts.sv
module issue_stage_asserts #(
    parameter int MD_LATENCY = 4
) (
    input logic                       clk,
    input logic                       reset,
    input logic                       flush,
    input logic                       dec_ready,
    input logic                       iss_ready,
    input logic [1:0]                 iss_valid,
    input pipe_pkg::dec_entry_t [1:0] iss_entry
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench for its summary
    int fire_count = 0;
    int md_quiet;
    pipe_pkg::dec_entry_t older;
    pipe_pkg::dec_entry_t younger;
    logic older_md;
    logic younger_md;
    logic raw_hit;
    logic bad_pair;
    logic md_go;

    assign older = iss_entry[1];
    assign younger = iss_entry[0];
    assign older_md = older.op == isa_pkg::OP_MD;
    assign younger_md = younger.op == isa_pkg::OP_MD;
    assign raw_hit = older.writes_rd && (older.rd != '0)
                     && ((older.rd == younger.rs) || (older.rd == younger.rt));
    // every condition under which the younger slot must stay back
    assign bad_pair = (younger.op == isa_pkg::OP_BRANCH) || (younger.op == isa_pkg::OP_TRAP)
                      || (older.op == isa_pkg::OP_TRAP) || raw_hit
                      || (older_md && younger_md)
                      || (older_md && (younger.op == isa_pkg::OP_HILO_RD));
    assign md_go = iss_ready && ((iss_valid[1] && older_md) || (iss_valid[0] && younger_md));

    // edges left on which no mult/div may issue
    always_ff @(posedge clk) begin
        if (reset || flush) md_quiet <= 0;
        else if (md_go) md_quiet <= MD_LATENCY;
        else if (md_quiet != 0) md_quiet <= md_quiet - 1;
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !dec_ready && (iss_valid == 2'b00))
        else begin $error("dec_ready or iss_valid high right after reset"); fire_count++; end
    a_slot_order: assert property (@(posedge clk) disable iff (reset)
        iss_valid != 2'b01)
        else begin $error("younger slot valid without the older one"); fire_count++; end
    a_pair_rules: assert property (@(posedge clk) disable iff (reset)
        iss_valid[0] |-> !bad_pair)
        else begin $error("forbidden pair issued together"); fire_count++; end
    a_delay_slot: assert property (@(posedge clk) disable iff (reset)
        (iss_valid[1] && (older.op == isa_pkg::OP_BRANCH)) |-> iss_valid[0])
        else begin $error("branch issued without its delay slot"); fire_count++; end
    a_md_spacing: assert property (@(posedge clk) disable iff (reset)
        md_go |-> (md_quiet == 0))
        else begin $error("mult/div issued while the unit is busy"); fire_count++; end
    a_hold_older: assert property (@(posedge clk) disable iff (reset)
        (!iss_ready && !flush && iss_valid[1])
        |=> flush || (iss_valid[1] && $stable(iss_entry[1])))
        else begin $error("older slot dropped or changed under back-pressure"); fire_count++; end
    a_hold_younger: assert property (@(posedge clk) disable iff (reset)
        (!iss_ready && !flush && iss_valid[0])
        |=> flush || (iss_valid[0] && $stable(iss_entry[0])))
        else begin $error("younger slot dropped or changed under back-pressure"); fire_count++; end
    a_flush_gap: assert property (@(posedge clk) disable iff (reset)
        flush |=> (iss_valid == 2'b00) && !dec_ready)
        else begin $error("issue or decode active in the cycle after flush"); fire_count++; end
    a_flush_back: assert property (@(posedge clk) disable iff (reset)
        ($past(flush) && !flush) |=> flush || dec_ready)
        else begin $error("dec_ready did not return after flush"); fire_count++; end

endmodule

bind issue_stage issue_stage_asserts #(.MD_LATENCY(MD_LATENCY)) u_chk (
    .clk(clk), .reset(reset), .flush(flush), .dec_ready(dec_ready),
    .iss_ready(iss_ready), .iss_valid(iss_valid), .iss_entry(iss_entry)
);

// File: testbench/issue_stage_tb.sv
module issue_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // five phases plus reset and drain, with margin
    localparam int CYCLE_LIMIT = 600;
    localparam int PHASE_LEN = 80;

    logic clk, reset, flush, dec_ready, iss_ready;
    logic [1:0] dec_valid, iss_valid, wb_en;
    pipe_pkg::dec_entry_t [1:0] dec_entry, iss_entry;
    isa_pkg::word_t [1:0] iss_rs_data, iss_rt_data, wb_data;
    isa_pkg::reg_idx_t [1:0] wb_rd;

    logic [31:0] rng_state;
    int cycle_count, error_count, phase;
    logic dec_taken;
    pipe_pkg::tag_t next_tag;
    // accepted entries in program order
    pipe_pkg::dec_entry_t exp_q[$];
    isa_pkg::word_t shadow[isa_pkg::NUM_REGS];
    // execute model with writebacks two cycles behind issue
    logic [1:0] wb1_en, wb2_en;
    isa_pkg::reg_idx_t [1:0] wb1_rd, wb2_rd;

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    issue_stage #(.QUEUE_DEPTH(8), .MD_LATENCY(4)) UUT (
        .clk(clk), .reset(reset), .flush(flush), .dec_valid(dec_valid),
        .dec_entry(dec_entry), .dec_ready(dec_ready), .iss_valid(iss_valid),
        .iss_entry(iss_entry), .iss_rs_data(iss_rs_data), .iss_rt_data(iss_rt_data),
        .iss_ready(iss_ready), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // op mix leans toward what each phase is after
    function automatic isa_pkg::op_class_t pick_op(logic [3:0] v);
        if (phase == 2) return (v < 8) ? isa_pkg::OP_MD : isa_pkg::OP_HILO_RD;
        if (phase == 3 && v < 5) return isa_pkg::OP_BRANCH;
        if (phase == 3 && v < 8) return isa_pkg::OP_TRAP;
        if (v < 8) return isa_pkg::OP_ALU;
        if (v < 10) return isa_pkg::OP_MD;
        if (v == 10) return isa_pkg::OP_HILO_RD;
        if (v < 13) return isa_pkg::OP_BRANCH;
        if (v == 13) return isa_pkg::OP_TRAP;
        return isa_pkg::OP_NOP;
    endfunction

    function automatic pipe_pkg::dec_entry_t make_entry(logic younger_slot);
        pipe_pkg::dec_entry_t e;
        logic [31:0] r;
        r = next_rand();
        e.tag = next_tag;
        next_tag = next_tag + 1'b1;
        e.op = pick_op(r[3:0]);
        // no branch or trap in slot 0 since it may be a delay slot
        if (younger_slot && (e.op == isa_pkg::OP_BRANCH || e.op == isa_pkg::OP_TRAP)) begin
            e.op = isa_pkg::OP_ALU;
        end
        // small register range so hazards show up often
        e.rs = {2'b00, r[6:4]};
        e.rt = {2'b00, r[9:7]};
        e.rd = {2'b00, r[12:10]};
        e.writes_rd = (e.op == isa_pkg::OP_ALU) || (e.op == isa_pkg::OP_HILO_RD);
        e.imm = r[31:16];
        return e;
    endfunction

    // register value as execute should see it
    // younger writeback wins
    function automatic isa_pkg::word_t expect_reg(isa_pkg::reg_idx_t r);
        if (r == '0) return '0;
        if (wb_en[0] && (wb_rd[0] == r)) return wb_data[0];
        if (wb_en[1] && (wb_rd[1] == r)) return wb_data[1];
        return shadow[r];
    endfunction

    task automatic check_word(string name, int i, isa_pkg::word_t exp, isa_pkg::word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s[%0d] expected %h actual %h", name, i, exp, act);
            error_count++;
        end
    endtask

    // drive on the falling edge, then check what the next edge takes
    task automatic step(logic feed);
        logic [31:0] r;
        pipe_pkg::dec_entry_t exp_entry;
        @(negedge clk);
        r = next_rand();
        flush = (phase == 4) && (r[4:0] == 5'd0);
        iss_ready = (phase == 1 || phase == 4) ? r[5] | r[6] : 1'b1;
        wb_en = wb2_en;
        wb_rd = wb2_rd;
        wb_data[0] = next_rand();
        wb_data[1] = next_rand();
        wb2_en = flush ? 2'b00 : wb1_en;
        wb2_rd = wb1_rd;
        wb1_en = 2'b00;
        if (!feed) begin
            dec_valid = 2'b00;
        end else if (dec_taken || dec_valid == 2'b00) begin
            // slot 0 alone is never offered
            dec_valid = (r[8:7] == 2'd0) ? 2'b00 : (r[8:7] == 2'd1) ? 2'b10 : 2'b11;
            dec_entry = '0;
            if (dec_valid[1]) begin
                dec_entry[1] = make_entry(1'b0);
            end
            // a branch always comes with its delay slot
            if (dec_entry[1].op == isa_pkg::OP_BRANCH) begin
                dec_valid = 2'b11;
            end
            if (dec_valid[0]) begin
                dec_entry[0] = make_entry(1'b1);
            end
        end
        #1;
        for (int i = 1; i >= 0; i--) begin
            if (iss_valid[i]) begin
                check_word("iss_rs_data", i, expect_reg(iss_entry[i].rs), iss_rs_data[i]);
                check_word("iss_rt_data", i, expect_reg(iss_entry[i].rt), iss_rt_data[i]);
            end
            if (iss_valid[i] && iss_ready) begin
                if (exp_q.size() == 0) begin
                    $display("entry issued with no accepted entry left to issue");
                    error_count++;
                end else begin
                    exp_entry = exp_q.pop_front();
                    if (exp_entry.tag !== iss_entry[i].tag) begin
                        $display("[ERROR] iss_entry.tag expected %h actual %h",
                                 exp_entry.tag, iss_entry[i].tag);
                        error_count++;
                    end else if (exp_entry !== iss_entry[i]) begin
                        $display("[ERROR] iss_entry[%0d] expected %h actual %h",
                                 i, exp_entry, iss_entry[i]);
                        error_count++;
                    end
                end
                wb1_en[i] = iss_entry[i].writes_rd && (iss_entry[i].rd != '0);
                wb1_rd[i] = iss_entry[i].rd;
            end
        end
        dec_taken = dec_ready && (dec_valid != 2'b00);
        if (dec_taken) begin
            exp_q.push_back(dec_entry[1]);
            if (dec_valid[0]) exp_q.push_back(dec_entry[0]);
        end
        if (flush) exp_q.delete();
        if (wb_en[1]) shadow[wb_rd[1]] = wb_data[1];
        if (wb_en[0]) shadow[wb_rd[0]] = wb_data[0];
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rng_state = 32'hef407e6e;
        cycle_count = 0;
        error_count = 0;
        phase = 0;
        reset = 1'b1;
        flush = 1'b0;
        iss_ready = 1'b0;
        dec_taken = 1'b0;
        dec_valid = '0;
        wb_en = '0;
        wb1_en = '0;
        wb2_en = '0;
        dec_entry = '0;
        wb_rd = '0;
        wb_data = '0;
        wb1_rd = '0;
        wb2_rd = '0;
        next_tag = '0;
        for (int k = 0; k < isa_pkg::NUM_REGS; k++) shadow[k] = '0;
        // load r1..r7 through writeback during reset
        for (int k = 1; k <= 10; k++) begin
            @(negedge clk);
            wb_en = (k < 8) ? 2'b10 : 2'b00;
            wb_rd[1] = isa_pkg::reg_idx_t'(k);
            wb_data[1] = next_rand();
            if (k < 8) shadow[k] = wb_data[1];
        end
        @(negedge clk);
        reset = 1'b0;
        wb_en = 2'b00;
        for (int c = 0; c < 5 * PHASE_LEN; c++) begin
            phase = c / PHASE_LEN;
            step(1'b1);
        end
        phase = 0;
        // drain what is still queued or in flight
        while (exp_q.size() != 0 || wb1_en != 2'b00 || wb2_en != 2'b00) step(1'b0);
        step(1'b0);
        $display("errors: testbench %0d, assertions %0d", error_count, UUT.u_chk.fire_count);
        if (error_count == 0 && UUT.u_chk.fire_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule
